// ==== include/cache_settings.svh ====
// cache geometry settings

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// front-end word address, without the control bit
`define CACHE_ADDR_W 12

// data word and its byte lanes
`define CACHE_DATA_W 32
`define CACHE_NBYTES 4

// 16 lines of 4 words
`define CACHE_NLINES_W 4
`define CACHE_OFFSET_W 2
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_NLINES_W - `CACHE_OFFSET_W)

// control registers and event counters
`define CACHE_REGSEL_W 2
`define CACHE_CNT_W 16

`endif

// ==== src/cache_pkg.sv ====
// cache shared types
`default_nettype none
`include "cache_settings.svh"

package cache_pkg;

   // address word seen as a cache location
   typedef struct packed {
      logic                        is_ctrl;
      logic [`CACHE_TAG_W-1:0]     tag;
      logic [`CACHE_NLINES_W-1:0]  index;
      logic [`CACHE_OFFSET_W-1:0]  offset;
   } cache_addr_t;

   // same word seen as a control register select
   typedef struct packed {
      logic                                      is_ctrl;
      logic [`CACHE_ADDR_W-`CACHE_REGSEL_W-1:0]  unused;
      logic [`CACHE_REGSEL_W-1:0]                regsel;
   } ctrl_addr_t;

   typedef union packed {
      cache_addr_t cache;
      ctrl_addr_t  regs;
   } fe_addr_u;

   typedef struct packed {
      logic                      we;
      fe_addr_u                  addr;
      logic [`CACHE_DATA_W-1:0]  wdata;
      logic [`CACHE_NBYTES-1:0]  wstrb;
   } fe_req_t;

   typedef struct packed {
      logic                      we;
      logic [`CACHE_ADDR_W-1:0]  addr;
      logic [`CACHE_DATA_W-1:0]  wdata;
      logic [`CACHE_NBYTES-1:0]  wstrb;
   } mem_req_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_evt_t;

   // a write to reg_read_hit invalidates, a write to reg_read_miss clears counters
   typedef enum logic [`CACHE_REGSEL_W-1:0] {
      reg_read_hit   = 2'd0,
      reg_read_miss  = 2'd1,
      reg_write_hit  = 2'd2,
      reg_write_miss = 2'd3
   } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== src/cache_front_end.sv ====
// cache front end
`default_nettype none
`include "cache_settings.svh"

module cache_front_end (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      req_i,
   input  cache_pkg::fe_req_t        fe_req_i,
   input  logic                      data_done_i,
   input  logic [`CACHE_DATA_W-1:0]  data_rdata_i,
   input  logic                      ctrl_done_i,
   input  logic [`CACHE_DATA_W-1:0]  ctrl_rdata_i,
   output logic                      ack_o,
   output logic [`CACHE_DATA_W-1:0]  rdata_o,
   output cache_pkg::fe_req_t        req_reg_o,
   output logic                      data_go_o,
   output logic                      ctrl_go_o
);

   typedef enum logic [1:0] {
      s_idle,
      s_wait,
      s_ack
   } state_t;

   state_t state_q;
   logic   is_ctrl;
   logic   start;
   logic   done;

   // top bit selects the control registers
   assign is_ctrl = fe_req_i.addr.regs.is_ctrl;
   assign start   = (state_q == s_idle) && req_i;
   assign done    = (state_q == s_wait) && (data_done_i || ctrl_done_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= s_idle;
         ack_o     <= 1'b0;
         data_go_o <= 1'b0;
         ctrl_go_o <= 1'b0;
      end else begin
         data_go_o <= 1'b0;
         ctrl_go_o <= 1'b0;
         case (state_q)
            s_idle: begin
               if (req_i) begin
                  data_go_o <= !is_ctrl;
                  ctrl_go_o <= is_ctrl;
                  state_q   <= s_wait;
               end
            end
            s_wait: begin
               if (data_done_i || ctrl_done_i) begin
                  ack_o   <= 1'b1;
                  state_q <= s_ack;
               end
            end
            s_ack: begin
               // hold ack until the host lets go of req
               if (!req_i) begin
                  ack_o   <= 1'b0;
                  state_q <= s_idle;
               end
            end
            default: state_q <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         req_reg_o <= fe_req_i;
      end
      if (done) begin
         rdata_o <= data_done_i ? data_rdata_i : ctrl_rdata_i;
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_memory.sv ====
// direct-mapped write-through cache memory
`default_nettype none
`include "cache_settings.svh"

module cache_memory (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      data_go_i,
   input  cache_pkg::fe_req_t        req_i,
   input  logic                      invalidate_i,
   input  logic                      be_done_i,
   input  logic [`CACHE_DATA_W-1:0]  be_rdata_i,
   output logic                      data_done_o,
   output logic [`CACHE_DATA_W-1:0]  data_rdata_o,
   output cache_pkg::cache_evt_t     evt_o,
   output logic                      be_go_o,
   output cache_pkg::mem_req_t       be_req_o
);

   localparam int NLINES = 1 << `CACHE_NLINES_W;
   localparam int NWORDS = 1 << (`CACHE_NLINES_W + `CACHE_OFFSET_W);

   typedef enum logic [2:0] {
      s_idle,
      s_lookup,
      s_fill,
      s_resp,
      s_write
   } state_t;

   state_t                                      state_q;
   logic [NLINES-1:0]                           valid_q;
   logic [`CACHE_OFFSET_W-1:0]                  fill_cnt_q;
   logic [`CACHE_TAG_W-1:0]                     tag_mem [NLINES];
   logic [`CACHE_DATA_W-1:0]                    data_mem [NWORDS];
   cache_pkg::cache_addr_t                      addr;
   logic                                        hit;
   logic                                        lookup;
   logic                                        fill_we;
   logic                                        fill_last;
   logic [`CACHE_NLINES_W+`CACHE_OFFSET_W-1:0]  word_idx;
   logic [`CACHE_NLINES_W+`CACHE_OFFSET_W-1:0]  fill_idx;

   assign addr      = req_i.addr.cache;
   assign hit       = valid_q[addr.index] && (tag_mem[addr.index] == addr.tag);
   assign lookup    = (state_q == s_lookup);
   assign fill_we   = (state_q == s_fill) && be_done_i;
   assign fill_last = (fill_cnt_q == '1);
   assign word_idx  = {addr.index, addr.offset};
   assign fill_idx  = {addr.index, fill_cnt_q};

   // fills walk the line from offset 0, writes go to the front word
   assign be_req_o.we    = req_i.we;
   assign be_req_o.addr  = {addr.tag, addr.index, req_i.we ? addr.offset : fill_cnt_q};
   assign be_req_o.wdata = req_i.wdata;
   assign be_req_o.wstrb = req_i.wstrb;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= s_idle;
         valid_q     <= '0;
         fill_cnt_q  <= '0;
         be_go_o     <= 1'b0;
         data_done_o <= 1'b0;
         evt_o       <= '0;
      end else begin
         be_go_o     <= 1'b0;
         data_done_o <= 1'b0;
         evt_o       <= '0;
         if (invalidate_i) begin
            valid_q <= '0;
         end
         case (state_q)
            s_idle: begin
               if (data_go_i) begin
                  state_q <= s_lookup;
               end
            end
            s_lookup: begin
               evt_o.read_hit   <= !req_i.we && hit;
               evt_o.read_miss  <= !req_i.we && !hit;
               evt_o.write_hit  <= req_i.we && hit;
               evt_o.write_miss <= req_i.we && !hit;
               if (req_i.we) begin
                  be_go_o <= 1'b1;
                  state_q <= s_write;
               end else if (hit) begin
                  data_done_o <= 1'b1;
                  state_q     <= s_idle;
               end else begin
                  fill_cnt_q <= '0;
                  be_go_o    <= 1'b1;
                  state_q    <= s_fill;
               end
            end
            s_fill: begin
               if (be_done_i) begin
                  if (fill_last) begin
                     valid_q[addr.index] <= 1'b1;
                     state_q             <= s_resp;
                  end else begin
                     fill_cnt_q <= fill_cnt_q + 1'b1;
                     be_go_o    <= 1'b1;
                  end
               end
            end
            s_resp: begin
               data_done_o <= 1'b1;
               state_q     <= s_idle;
            end
            s_write: begin
               if (be_done_i) begin
                  data_done_o <= 1'b1;
                  state_q     <= s_idle;
               end
            end
            default: state_q <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_we) begin
         data_mem[fill_idx] <= be_rdata_i;
      end
      if (fill_we && fill_last) begin
         tag_mem[addr.index] <= addr.tag;
      end
      // write hit merges the strobed bytes
      if (lookup && req_i.we && hit) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (req_i.wstrb[b]) begin
               data_mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
      if ((lookup && !req_i.we && hit) || (state_q == s_resp)) begin
         data_rdata_o <= data_mem[word_idx];
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_back_end.sv ====
// cache back-end memory master
`default_nettype none
`include "cache_settings.svh"

module cache_back_end (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      be_go_i,
   input  cache_pkg::mem_req_t       be_req_i,
   input  logic                      mem_ack_i,
   input  logic [`CACHE_DATA_W-1:0]  mem_rdata_i,
   output logic                      be_done_o,
   output logic [`CACHE_DATA_W-1:0]  be_rdata_o,
   output logic                      mem_req_o,
   output cache_pkg::mem_req_t       mem_o
);

   typedef enum logic [1:0] {
      s_idle,
      s_req,
      s_drop
   } state_t;

   state_t state_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= s_idle;
         mem_req_o <= 1'b0;
         be_done_o <= 1'b0;
      end else begin
         be_done_o <= 1'b0;
         case (state_q)
            s_idle: begin
               if (be_go_i) begin
                  mem_req_o <= 1'b1;
                  state_q   <= s_req;
               end
            end
            s_req: begin
               if (mem_ack_i) begin
                  mem_req_o <= 1'b0;
                  state_q   <= s_drop;
               end
            end
            s_drop: begin
               // four-phase, wait for ack to return low
               if (!mem_ack_i) begin
                  be_done_o <= 1'b1;
                  state_q   <= s_idle;
               end
            end
            default: state_q <= s_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if ((state_q == s_idle) && be_go_i) begin
         mem_o <= be_req_i;
      end
      if ((state_q == s_req) && mem_ack_i) begin
         be_rdata_o <= mem_rdata_i;
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_control.sv ====
// cache control registers and counters
`default_nettype none
`include "cache_settings.svh"

module cache_control (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      ctrl_go_i,
   input  cache_pkg::fe_req_t        req_i,
   input  cache_pkg::cache_evt_t     evt_i,
   output logic                      ctrl_done_o,
   output logic [`CACHE_DATA_W-1:0]  ctrl_rdata_o,
   output logic                      invalidate_o
);

   logic [`CACHE_CNT_W-1:0] cnt_q [4];
   logic [3:0]              evt_vec;
   cache_pkg::ctrl_reg_e    sel;
   logic                    clear;

   assign sel     = cache_pkg::ctrl_reg_e'(req_i.addr.regs.regsel);
   // counter order follows the register map
   assign evt_vec = {evt_i.write_miss, evt_i.write_hit, evt_i.read_miss, evt_i.read_hit};
   assign clear   = ctrl_go_i && req_i.we && (sel == cache_pkg::reg_read_miss);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_done_o  <= 1'b0;
         invalidate_o <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         ctrl_done_o  <= ctrl_go_i;
         invalidate_o <= ctrl_go_i && req_i.we && (sel == cache_pkg::reg_read_hit);
         for (int i = 0; i < 4; i++) begin
            if (clear) begin
               cnt_q[i] <= '0;
            end else if (evt_vec[i] && (cnt_q[i] != '1)) begin
               // saturate at all ones
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_go_i) begin
         ctrl_rdata_o <= req_i.we ? '0 :
                         {{(`CACHE_DATA_W-`CACHE_CNT_W){1'b0}}, cnt_q[sel]};
      end
   end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
// write-through cache top level
`default_nettype none
`include "cache_settings.svh"

module cache_top (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  logic                      req_i,
   input  cache_pkg::fe_req_t        fe_req_i,
   output logic                      ack_o,
   output logic [`CACHE_DATA_W-1:0]  rdata_o,
   output logic                      mem_req_o,
   output cache_pkg::mem_req_t       mem_o,
   input  logic                      mem_ack_i,
   input  logic [`CACHE_DATA_W-1:0]  mem_rdata_i
);

   cache_pkg::fe_req_t        req_reg;
   cache_pkg::cache_evt_t     evt;
   cache_pkg::mem_req_t       be_req;
   logic                      data_go;
   logic                      ctrl_go;
   logic                      data_done;
   logic                      ctrl_done;
   logic                      invalidate;
   logic                      be_go;
   logic                      be_done;
   logic [`CACHE_DATA_W-1:0]  data_rdata;
   logic [`CACHE_DATA_W-1:0]  ctrl_rdata;
   logic [`CACHE_DATA_W-1:0]  be_rdata;

   cache_front_end front_end (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .req_i        (req_i),
      .fe_req_i     (fe_req_i),
      .data_done_i  (data_done),
      .data_rdata_i (data_rdata),
      .ctrl_done_i  (ctrl_done),
      .ctrl_rdata_i (ctrl_rdata),
      .ack_o        (ack_o),
      .rdata_o      (rdata_o),
      .req_reg_o    (req_reg),
      .data_go_o    (data_go),
      .ctrl_go_o    (ctrl_go)
   );

   cache_memory memory (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .data_go_i    (data_go),
      .req_i        (req_reg),
      .invalidate_i (invalidate),
      .be_done_i    (be_done),
      .be_rdata_i   (be_rdata),
      .data_done_o  (data_done),
      .data_rdata_o (data_rdata),
      .evt_o        (evt),
      .be_go_o      (be_go),
      .be_req_o     (be_req)
   );

   cache_control control (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .ctrl_go_i    (ctrl_go),
      .req_i        (req_reg),
      .evt_i        (evt),
      .ctrl_done_o  (ctrl_done),
      .ctrl_rdata_o (ctrl_rdata),
      .invalidate_o (invalidate)
   );

   cache_back_end back_end (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .be_go_i      (be_go),
      .be_req_i     (be_req),
      .mem_ack_i    (mem_ack_i),
      .mem_rdata_i  (mem_rdata_i),
      .be_done_o    (be_done),
      .be_rdata_o   (be_rdata),
      .mem_req_o    (mem_req_o),
      .mem_o        (mem_o)
   );

endmodule

`default_nettype wire

// ==== testbench/cache_checker.sv ====
// cache handshake assertions
`default_nettype none

module cache_checker (
   input logic                 clk_i,
   input logic                 arst_n_i,
   input logic                 req_i,
   input logic                 ack_o,
   input logic                 mem_req_o,
   input logic                 mem_ack_i,
   input cache_pkg::mem_req_t  mem_o
);

   // host side, ack only answers a pending request
   ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(ack_o) |-> $past(req_i))
      else $error("ack_o rose while req_i was low");

   // memory side, transfer held until acknowledged
   mem_bus_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (mem_req_o && !mem_ack_i) |=> $stable(mem_o))
      else $error("mem_o changed while mem_req_o waited for mem_ack_i");

   idle_in_reset: assert property (@(posedge clk_i)
      !arst_n_i |=> (!ack_o && !mem_req_o))
      else $error("ack_o or mem_req_o high after reset");

endmodule

bind cache_top cache_checker checks (
   .clk_i     (clk_i),
   .arst_n_i  (arst_n_i),
   .req_i     (req_i),
   .ack_o     (ack_o),
   .mem_req_o (mem_req_o),
   .mem_ack_i (mem_ack_i),
   .mem_o     (mem_o)
);

`default_nettype wire

// ==== testbench/cache_tb.sv ====
// cache testbench
`default_nettype none
`include "cache_settings.svh"

module cache_tb;

   localparam int          FE_ADDR_W   = `CACHE_ADDR_W + 1;
   localparam int          MEM_WORDS   = 1 << `CACHE_ADDR_W;
   localparam int          ACK_TIMEOUT = 200;
   localparam logic [31:0] MEM_PATTERN = 32'ha5c3_0000;
   localparam string       GOLDEN_FILE = "testbench/cache_golden.txt";

   // operation codes of the golden file
   localparam logic [3:0] OP_READ  = 4'h0;
   localparam logic [3:0] OP_WRITE = 4'h1;
   localparam logic [3:0] OP_CHECK = 4'h2;

   logic                      clk;
   logic                      arst_n;
   logic                      req;
   cache_pkg::fe_req_t        fe_req;
   logic                      ack;
   logic [`CACHE_DATA_W-1:0]  rdata;
   logic                      mem_req;
   cache_pkg::mem_req_t       mem_bus;
   logic                      mem_ack = 1'b0;
   logic [`CACHE_DATA_W-1:0]  mem_rdata = '0;

   logic [`CACHE_DATA_W-1:0]  backing [MEM_WORDS];
   int                        seed = 61520;
   int                        delay;
   int                        errors;
   int                        tests;
   int                        passed;
   logic                      timed_out;
   int                        fd;
   logic [8*128-1:0]          line;
   logic [3:0]                op;
   logic [FE_ADDR_W-1:0]      addr;
   logic [`CACHE_DATA_W-1:0]  wdata;
   logic [`CACHE_NBYTES-1:0]  strb;
   logic [`CACHE_DATA_W-1:0]  expected;

   cache_top dut (
      .clk_i       (clk),
      .arst_n_i    (arst_n),
      .req_i       (req),
      .fe_req_i    (fe_req),
      .ack_o       (ack),
      .rdata_o     (rdata),
      .mem_req_o   (mem_req),
      .mem_o       (mem_bus),
      .mem_ack_i   (mem_ack),
      .mem_rdata_i (mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // backing memory, answers on the falling edge after 0 to 3 cycles
   always @(negedge clk) begin
      if (!arst_n) begin
         mem_ack   = 1'b0;
         mem_rdata = '0;
         delay     = -1;
         for (int a = 0; a < MEM_WORDS; a++) begin
            backing[a] = a ^ MEM_PATTERN;
         end
      end else if (mem_ack) begin
         if (!mem_req) begin
            mem_ack = 1'b0;
         end
      end else if (mem_req) begin
         if (delay < 0) begin
            delay = $random(seed) & 3;
         end
         if (delay == 0) begin
            if (mem_bus.we) begin
               for (int b = 0; b < `CACHE_NBYTES; b++) begin
                  if (mem_bus.wstrb[b]) begin
                     backing[mem_bus.addr][8*b +: 8] = mem_bus.wdata[8*b +: 8];
                  end
               end
            end else begin
               mem_rdata = backing[mem_bus.addr];
            end
            mem_ack = 1'b1;
            delay   = -1;
         end else begin
            delay = delay - 1;
         end
      end
   end

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp_value);
      if (got !== exp_value) begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp_value);
         errors++;
      end
   endtask

   task automatic wait_for_ack(input logic level);
      int cycles;
      cycles = 0;
      while ((ack !== level) && (cycles < ACK_TIMEOUT)) begin
         @(negedge clk);
         cycles++;
      end
      if (ack !== level) begin
         $display("timeout on test %0d, ack_o did not go to %0d within %0d cycles",
                  tests, level, ACK_TIMEOUT);
         timed_out = 1'b1;
      end
   endtask

   // one four-phase transfer on the front port
   task automatic issue_request(input logic we, input logic [FE_ADDR_W-1:0] req_addr,
                                input logic [31:0] req_wdata, input logic [3:0] req_strb,
                                output logic [31:0] got);
      @(negedge clk);
      fe_req.we    = we;
      fe_req.addr  = req_addr;
      fe_req.wdata = req_wdata;
      fe_req.wstrb = req_strb;
      req          = 1'b1;
      wait_for_ack(1'b1);
      got = rdata;
      req = 1'b0;
      if (!timed_out) begin
         wait_for_ack(1'b0);
      end
   endtask

   task automatic run_test(input logic [3:0] t_op, input logic [FE_ADDR_W-1:0] t_addr,
                           input logic [31:0] t_wdata, input logic [3:0] t_strb,
                           input logic [31:0] t_expected);
      logic [31:0] got;
      int          errors_before;
      string       kind;
      errors_before = errors;
      tests++;
      case (t_op)
         OP_READ: begin
            kind = "read";
            issue_request(1'b0, t_addr, t_wdata, t_strb, got);
            if (!timed_out) begin
               compare_word("rdata_o", got, t_expected);
            end
         end
         OP_WRITE: begin
            kind = "write";
            issue_request(1'b1, t_addr, t_wdata, t_strb, got);
         end
         OP_CHECK: begin
            kind = "check";
            compare_word($sformatf("backing[%03h]", t_addr[`CACHE_ADDR_W-1:0]),
                         backing[t_addr[`CACHE_ADDR_W-1:0]], t_expected);
         end
         default: begin
            kind = "unknown";
            $display("test %0d has an unknown operation code %0h", tests, t_op);
            errors++;
         end
      endcase
      if ((errors == errors_before) && !timed_out) begin
         passed++;
         $display("test %0d %s %04h ok", tests, kind, t_addr);
      end else begin
         $display("test %0d %s %04h failed", tests, kind, t_addr);
      end
   endtask

   initial begin
      req       = 1'b0;
      fe_req    = '0;
      arst_n    = 1'b0;
      errors    = 0;
      tests     = 0;
      passed    = 0;
      timed_out = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0) begin
         $display("could not open the golden file %s", GOLDEN_FILE);
         errors++;
      end else begin
         // lines that do not hold five hex fields are comments
         while (!$feof(fd) && !timed_out) begin
            if ($fgets(line, fd) != 0) begin
               if ($sscanf(line, "%h %h %h %h %h", op, addr, wdata, strb, expected) == 5) begin
                  run_test(op, addr, wdata, strb, expected);
               end
            end
         end
         $fclose(fd);
      end
      if (tests == 0) begin
         $display("no test was read from the golden file");
         errors++;
      end

      $display("tests %0d, passed %0d, failed %0d", tests, passed, tests - passed);
      if ((errors == 0) && !timed_out) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/cache_golden.txt ====
# columns (hex) op addr wdata strb expected; op 0 read, 1 write, 2 check backing word
# addr is the 13-bit front address word, expected is used by reads and checks only
0 0040 00000000 0 a5c30040
0 0041 00000000 0 a5c30041
0 1000 00000000 0 00000001
0 1001 00000000 0 00000001
1 0042 11223344 5 00000000
0 0042 00000000 0 a5220044
2 0042 00000000 0 a5220044
0 1002 00000000 0 00000001
1 0105 deadbeef f 00000000
2 0105 00000000 0 deadbeef
0 0105 00000000 0 deadbeef
0 1001 00000000 0 00000002
0 1003 00000000 0 00000001
0 0080 00000000 0 a5c30080
0 0042 00000000 0 a5220044
0 1001 00000000 0 00000004
0 1000 00000000 0 00000002
1 1000 00000000 f 00000000
0 0041 00000000 0 a5c30041
0 1001 00000000 0 00000005
1 1001 00000000 f 00000000
0 1000 00000000 0 00000000
0 1001 00000000 0 00000000
0 1002 00000000 0 00000000
0 1003 00000000 0 00000000

// ==== verilog.f ====
+incdir+include
src/cache_pkg.sv
src/cache_front_end.sv
src/cache_memory.sv
src/cache_back_end.sv
src/cache_control.sv
src/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = cache_tb
FILELIST  = verilog.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
